// File: Makefile
# Verilator flow for the execute stage
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_exu
RTL_TOP    ?= exu_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: exu_alu.sv
////////////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU
// Add, subtract, logic, shifts, compares and pass-through of operand B
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_alu #(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  exu_pkg::alu_op_e i_op,
   input  logic [XLEN-1:0]  i_a,
   input  logic [XLEN-1:0]  i_b,
   output logic [XLEN-1:0]  o_result
);

   import exu_pkg::*;

   localparam int SHW = $clog2(XLEN);

   logic [SHW-1:0]  shamt;
   logic [XLEN-1:0] sum;
   logic [XLEN-1:0] diff;
   logic            lt_signed;
   logic            lt_unsigned;

   assign shamt       = i_b[SHW-1:0];              // Low bits of B only
   assign sum         = i_a + i_b;
   assign diff        = i_a - i_b;
   assign lt_signed   = $signed(i_a) < $signed(i_b);
   assign lt_unsigned = i_a < i_b;

   always_comb begin
      case (i_op)
         ALU_ADD:   o_result = sum;
         ALU_SUB:   o_result = diff;
         ALU_AND:   o_result = i_a & i_b;
         ALU_OR:    o_result = i_a | i_b;
         ALU_XOR:   o_result = i_a ^ i_b;
         ALU_SLL:   o_result = i_a << shamt;
         ALU_SRL:   o_result = i_a >> shamt;
         ALU_SRA:   o_result = $signed(i_a) >>> shamt;
         ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt_signed};
         ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
         ALU_PASSB: o_result = i_b;
         default:   o_result = '0;                   // Unused encodings
      endcase
   end

endmodule

// File: exu_ctl.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage control
// X-stage valid and result register under the data enable, lower flush
// kill, and divider start and kill qualification
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_ctl (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic                     i_data_en,
   input  logic                     i_flush_lower,
   input  logic                     i_alu_valid_d,
   input  logic                     i_mul_valid_d,
   input  logic                     i_div_valid_d,
   input  logic                     i_div_cancel,
   input  logic                     i_div_busy,
   input  logic [exu_pkg::XLEN-1:0] i_alu_result,
   input  logic [exu_pkg::XLEN-1:0] i_mul_result,
   output logic                     o_valid_x,
   output logic [exu_pkg::XLEN-1:0] o_result_x,
   output logic                     o_div_start,
   output logic                     o_div_kill
);

   import exu_pkg::*;

   logic            issue_d;
   logic            mul_sel_d;
   logic [XLEN-1:0] result_d;

   assign issue_d   = i_alu_valid_d | i_mul_valid_d;
   assign mul_sel_d = i_mul_valid_d;
   assign result_d  = mul_sel_d ? i_mul_result : i_alu_result;

   // Flush wins over a new issue in the same cycle
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_valid_x <= 1'b0;
      end else if (i_flush_lower) begin
         o_valid_x <= 1'b0;
      end else if (i_data_en) begin
         o_valid_x <= issue_d;
      end
   end

   // Holds across stalls and idle cycles, feeds the X bypass
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_result_x <= '0;
      end else if (i_data_en && issue_d) begin
         o_result_x <= result_d;
      end
   end

   // Divider runs off the data enable
   assign o_div_kill  = i_flush_lower | i_div_cancel;
   assign o_div_start = i_div_valid_d & ~i_div_busy & ~o_div_kill;

endmodule

// File: exu_div.sv
////////////////////////////////////////////////////////////////////////////
// Iterative radix-2 restoring divider
// One quotient bit per cycle on operand magnitudes, then a sign fixup
// cycle and a one-cycle write strobe; cancel drops back to idle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_div #(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic            clk,
   input  logic            i_arst_n,
   input  logic            i_start,
   input  logic            i_cancel,
   input  logic            i_unsigned,
   input  logic            i_rem,
   input  logic [XLEN-1:0] i_dividend,
   input  logic [XLEN-1:0] i_divisor,
   output logic            o_busy,
   output logic            o_wren,
   output logic [XLEN-1:0] o_result
);

   import exu_pkg::*;

   localparam int CNT_W = $clog2(XLEN);

   div_state_e       state;
   logic [CNT_W-1:0] cnt;
   logic [XLEN-1:0]  quot;                       // Dividend in, quotient out
   logic [XLEN-1:0]  rem;
   logic [XLEN-1:0]  dvsr;
   logic             q_neg;
   logic             r_neg;
   logic             rem_sel;
   logic             a_neg;
   logic             b_neg;
   logic [XLEN:0]    rem_shift;
   logic [XLEN:0]    rem_diff;
   logic [XLEN-1:0]  q_final;
   logic [XLEN-1:0]  r_final;

   assign a_neg = ~i_unsigned & i_dividend[XLEN-1];
   assign b_neg = ~i_unsigned & i_divisor[XLEN-1];

   assign rem_shift = {rem, quot[XLEN-1]};
   assign rem_diff  = rem_shift - {1'b0, dvsr};  // MSB set means restore

   assign q_final = q_neg ? -quot : quot;
   assign r_final = r_neg ? -rem  : rem;

   assign o_busy = (state != DIV_IDLE);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state  <= DIV_IDLE;
         cnt    <= '0;
         o_wren <= 1'b0;
      end else begin
         o_wren <= 1'b0;
         case (state)
            DIV_IDLE: begin
               if (i_start) begin
                  state <= DIV_RUN;
                  cnt   <= '0;
               end
            end
            DIV_RUN: begin
               if (i_cancel) begin
                  state <= DIV_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
                  if (cnt == CNT_W'(XLEN-1)) begin
                     state <= DIV_FIX;
                  end
               end
            end
            DIV_FIX: begin
               state  <= DIV_IDLE;
               o_wren <= ~i_cancel;              // Killed divide never writes
            end
            default: state <= DIV_IDLE;
         endcase
      end
   end

   // Divide by zero falls out as all ones and the dividend, with the
   // quotient sign flip suppressed; MIN / -1 wraps back to MIN
   always_ff @(posedge clk) begin
      if (state == DIV_IDLE && i_start) begin
         quot    <= a_neg ? -i_dividend : i_dividend;
         rem     <= '0;
         dvsr    <= b_neg ? -i_divisor : i_divisor;
         q_neg   <= (a_neg ^ b_neg) & (|i_divisor);
         r_neg   <= a_neg;                       // Remainder follows dividend
         rem_sel <= i_rem;
      end else if (state == DIV_RUN) begin
         quot <= {quot[XLEN-2:0], ~rem_diff[XLEN]};
         rem  <= rem_diff[XLEN] ? rem_shift[XLEN-1:0] : rem_diff[XLEN-1:0];
      end else if (state == DIV_FIX) begin
         o_result <= rem_sel ? r_final : q_final;
      end
   end

endmodule

// File: exu_mul.sv
////////////////////////////////////////////////////////////////////////////
// Single-cycle multiplier
// Per-operand signedness, returns the low or high half of the product
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_mul #(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic [XLEN-1:0] i_a,
   input  logic [XLEN-1:0] i_b,
   input  logic            i_a_signed,
   input  logic            i_b_signed,
   input  logic            i_high,
   output logic [XLEN-1:0] o_result
);

   logic            a_sext;
   logic            b_sext;
   logic [2*XLEN-1:0] a_ext;
   logic [2*XLEN-1:0] b_ext;
   logic [2*XLEN-1:0] product;

   assign a_sext = i_a_signed & i_a[XLEN-1];
   assign b_sext = i_b_signed & i_b[XLEN-1];

   // Double-width extension makes one unsigned multiply cover
   // MUL, MULH, MULHSU and MULHU
   assign a_ext = {{XLEN{a_sext}}, i_a};
   assign b_ext = {{XLEN{b_sext}}, i_b};

   assign product = a_ext * b_ext;               // Truncated to 2*XLEN

   assign o_result = i_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

// File: exu_operand_mux.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage operand selection
// Four-way forwarding plus PC, GPR and immediate sources for the ALU
// operands and the multiplier and divider operands
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_operand_mux #(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic                          i_rs1_en,
   input  logic                          i_rs2_en,
   input  logic                          i_select_pc,
   input  logic [XLEN-1:0]               i_gpr_rs1,
   input  logic [XLEN-1:0]               i_gpr_rs2,
   input  logic [XLEN-1:0]               i_immed,
   input  logic [XLEN-1:1]               i_pc,           // Halfword address
   input  logic [exu_pkg::BYP_SRC_N-1:0] i_rs1_bypass_en,
   input  logic [exu_pkg::BYP_SRC_N-1:0] i_rs2_bypass_en,
   input  logic [XLEN-1:0]               i_result_r,
   input  logic [XLEN-1:0]               i_lsu_result_m,
   input  logic [XLEN-1:0]               i_result_x,
   input  logic [XLEN-1:0]               i_nonblock_load_data,
   output logic [XLEN-1:0]               o_alu_a,
   output logic [XLEN-1:0]               o_alu_b,
   output logic [XLEN-1:0]               o_muldiv_rs1,
   output logic [XLEN-1:0]               o_muldiv_rs2
);

   import exu_pkg::*;

   logic [XLEN-1:0] byp_src [BYP_SRC_N];
   logic [XLEN-1:0] rs1_byp_data;
   logic [XLEN-1:0] rs2_byp_data;
   logic            rs1_byp;
   logic            rs2_byp;
   logic [XLEN-1:0] rs1_gpr;

   assign byp_src[BYP_R]  = i_result_r;
   assign byp_src[BYP_M]  = i_lsu_result_m;
   assign byp_src[BYP_X]  = i_result_x;
   assign byp_src[BYP_NB] = i_nonblock_load_data;

   // Enables are one-hot from decode, so an OR merge is enough
   always_comb begin
      rs1_byp_data = '0;
      rs2_byp_data = '0;
      for (int i = 0; i < BYP_SRC_N; i++) begin
         rs1_byp_data = rs1_byp_data | ({XLEN{i_rs1_bypass_en[i]}} & byp_src[i]);
         rs2_byp_data = rs2_byp_data | ({XLEN{i_rs2_bypass_en[i]}} & byp_src[i]);
      end
   end

   assign rs1_byp = |i_rs1_bypass_en;
   assign rs2_byp = |i_rs2_bypass_en;
   assign rs1_gpr = i_rs1_en ? i_gpr_rs1 : '0;

   assign o_alu_a = rs1_byp     ? rs1_byp_data :
                    i_select_pc ? {i_pc, 1'b0} :  // JAL and AUIPC
                                  rs1_gpr;

   assign o_alu_b = rs2_byp  ? rs2_byp_data :
                    i_rs2_en ? i_gpr_rs2    :
                               i_immed;

   assign o_muldiv_rs1 = rs1_byp ? rs1_byp_data : rs1_gpr;  // Never the PC
   assign o_muldiv_rs2 = o_alu_b;

endmodule

// File: exu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage shared definitions
// Data path width, forwarding source order, ALU opcodes and the
// divider state encoding used across the integer execute stage
////////////////////////////////////////////////////////////////////////////
package exu_pkg;

   localparam int XLEN      = 32;          // Integer data path width
   localparam int BYP_SRC_N = 4;           // Forwarding sources per operand

   // Bit positions inside the bypass enable vectors
   localparam int BYP_R  = 0;              // R-stage result
   localparam int BYP_M  = 1;              // M-stage load result
   localparam int BYP_X  = 2;              // Own X-stage result
   localparam int BYP_NB = 3;              // Non-blocking load data

   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_AND   = 4'd2,
      ALU_OR    = 4'd3,
      ALU_XOR   = 4'd4,
      ALU_SLL   = 4'd5,
      ALU_SRL   = 4'd6,
      ALU_SRA   = 4'd7,
      ALU_SLT   = 4'd8,
      ALU_SLTU  = 4'd9,
      ALU_PASSB = 4'd10                    // B straight through, LUI
   } alu_op_e;

   // Divider sequencer states
   typedef enum logic [1:0] {
      DIV_IDLE = 2'd0,                     // Free to accept a divide
      DIV_RUN  = 2'd1,                     // One restoring step per cycle
      DIV_FIX  = 2'd2                      // Sign correction and write
   } div_state_e;

endpackage

// File: exu_tests.txt
# kind ctl a b expected (hex); alu ctl = op | 10 immediate B | 20 PC as A
# mul ctl = rs1 sign, rs2 sign, high; div ctl = unsigned, rem; byp ctl = source, 4 on rs2
alu 00 00000005 00000007 0000000c
alu 01 00000005 00000007 fffffffe
alu 02 f0f0ff00 0ff0f0f0 00f0f000
alu 03 f0f0ff00 0ff0f0f0 fff0fff0
alu 04 f0f0ff00 0ff0f0f0 ff000ff0
alu 05 00000003 00000024 00000030
alu 06 80000000 0000001f 00000001
alu 07 80000000 0000001f ffffffff
alu 08 ffffffff 00000001 00000001
alu 09 ffffffff 00000001 00000000
alu 1a 12345678 abcde000 abcde000
alu 10 00000010 fffffff0 00000000
alu 30 00001001 00000004 00001004
mul 03 00000007 fffffffd ffffffeb
mul 07 ffffffff ffffffff 00000000
mul 07 80000000 80000000 40000000
mul 04 ffffffff ffffffff fffffffe
mul 05 ffffffff 00000002 ffffffff
mul 00 12345678 00000010 23456780
mul 03 ffffffff ffffffff 00000001
byp 00 11111111 22222222 33333333
byp 01 01000000 00000234 01000234
byp 03 0000abcd 00001111 0000bcde
byp 02 00000100 00000023 00000123
byp 04 11111111 22222222 33333333
byp 06 00000005 00000070 00000075
div 00 00000014 00000006 00000003
div 00 ffffffec 00000006 fffffffd
div 02 ffffffec 00000006 fffffffe
div 02 00000014 fffffffa 00000002
div 01 ffffffff 00000002 7fffffff
div 03 ffffffff 00000007 00000003
div 00 00000064 00000000 ffffffff
div 02 00000064 00000000 00000064
div 02 ffffffec 00000000 ffffffec
div 00 80000000 ffffffff 80000000
div 02 80000000 ffffffff 00000000
cancel 00 00000064 00000007 00000000
stall 00 00000003 00000004 00000007
flush 00 0000000a 00000001 0000000b

// File: exu_top.sv
////////////////////////////////////////////////////////////////////////////
// Integer execute stage
// Operand forwarding, ALU, multiplier and iterative divider around the
// X-stage control and result register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module exu_top #(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  logic                          i_data_en,          // X-stage enable
   input  logic                          i_flush_lower,
   input  logic                          i_alu_valid_d,
   input  exu_pkg::alu_op_e              i_alu_op_d,
   input  logic                          i_mul_valid_d,
   input  logic                          i_mul_rs1_sign,
   input  logic                          i_mul_rs2_sign,
   input  logic                          i_mul_high,
   input  logic                          i_div_valid_d,
   input  logic                          i_div_unsigned,
   input  logic                          i_div_rem,
   input  logic                          i_div_cancel,
   input  logic                          i_rs1_en,
   input  logic                          i_rs2_en,
   input  logic                          i_select_pc,
   input  logic [XLEN-1:0]               i_gpr_rs1,
   input  logic [XLEN-1:0]               i_gpr_rs2,
   input  logic [XLEN-1:0]               i_immed,
   input  logic [XLEN-1:1]               i_pc,
   input  logic [exu_pkg::BYP_SRC_N-1:0] i_rs1_bypass_en,
   input  logic [exu_pkg::BYP_SRC_N-1:0] i_rs2_bypass_en,
   input  logic [XLEN-1:0]               i_result_r,
   input  logic [XLEN-1:0]               i_lsu_result_m,
   input  logic [XLEN-1:0]               i_nonblock_load_data,
   output logic [XLEN-1:0]               o_result_x,
   output logic                          o_valid_x,
   output logic [XLEN-1:0]               o_div_result,
   output logic                          o_div_wren,
   output logic                          o_div_busy
);

   logic [XLEN-1:0] alu_a;
   logic [XLEN-1:0] alu_b;
   logic [XLEN-1:0] muldiv_rs1;
   logic [XLEN-1:0] muldiv_rs2;
   logic [XLEN-1:0] alu_result;
   logic [XLEN-1:0] mul_result;
   logic            div_start;
   logic            div_kill;

   exu_operand_mux #(.XLEN(XLEN)) u_opmux (
      .i_rs1_en             (i_rs1_en),
      .i_rs2_en             (i_rs2_en),
      .i_select_pc          (i_select_pc),
      .i_gpr_rs1            (i_gpr_rs1),
      .i_gpr_rs2            (i_gpr_rs2),
      .i_immed              (i_immed),
      .i_pc                 (i_pc),
      .i_rs1_bypass_en      (i_rs1_bypass_en),
      .i_rs2_bypass_en      (i_rs2_bypass_en),
      .i_result_r           (i_result_r),
      .i_lsu_result_m       (i_lsu_result_m),
      .i_result_x           (o_result_x),             // Own result fed back
      .i_nonblock_load_data (i_nonblock_load_data),
      .o_alu_a              (alu_a),
      .o_alu_b              (alu_b),
      .o_muldiv_rs1         (muldiv_rs1),
      .o_muldiv_rs2         (muldiv_rs2)
   );

   exu_alu #(.XLEN(XLEN)) u_alu (
      .i_op     (i_alu_op_d),
      .i_a      (alu_a),
      .i_b      (alu_b),
      .o_result (alu_result)
   );

   exu_mul #(.XLEN(XLEN)) u_mul (
      .i_a        (muldiv_rs1),
      .i_b        (muldiv_rs2),
      .i_a_signed (i_mul_rs1_sign),
      .i_b_signed (i_mul_rs2_sign),
      .i_high     (i_mul_high),
      .o_result   (mul_result)
   );

   exu_div #(.XLEN(XLEN)) u_div (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_start    (div_start),
      .i_cancel   (div_kill),
      .i_unsigned (i_div_unsigned),
      .i_rem      (i_div_rem),
      .i_dividend (muldiv_rs1),
      .i_divisor  (muldiv_rs2),
      .o_busy     (o_div_busy),
      .o_wren     (o_div_wren),
      .o_result   (o_div_result)
   );

   exu_ctl u_ctl (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_data_en     (i_data_en),
      .i_flush_lower (i_flush_lower),
      .i_alu_valid_d (i_alu_valid_d),
      .i_mul_valid_d (i_mul_valid_d),
      .i_div_valid_d (i_div_valid_d),
      .i_div_cancel  (i_div_cancel),
      .i_div_busy    (o_div_busy),
      .i_alu_result  (alu_result),
      .i_mul_result  (mul_result),
      .o_valid_x     (o_valid_x),
      .o_result_x    (o_result_x),
      .o_div_start   (div_start),
      .o_div_kill    (div_kill)
   );

endmodule

// File: filelist.f
exu_pkg.sv
exu_operand_mux.sv
exu_alu.sv
exu_mul.sv
exu_div.sv
exu_ctl.sv
exu_top.sv
tb_exu.sv

// File: tb_exu.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage testbench
// Reads operation vectors, drives the execute stage top level and
// compares the X-stage and divider results with the expected values
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_exu;

   import exu_pkg::*;

   localparam int W       = exu_pkg::XLEN;
   localparam int DIV_LAT = W + 2;                 // Edges from accept to wren

   logic                 clk;
   logic                 i_arst_n;
   logic                 i_data_en;
   logic                 i_flush_lower;
   logic                 i_alu_valid_d;
   alu_op_e              i_alu_op_d;
   logic                 i_mul_valid_d;
   logic                 i_mul_rs1_sign;
   logic                 i_mul_rs2_sign;
   logic                 i_mul_high;
   logic                 i_div_valid_d;
   logic                 i_div_unsigned;
   logic                 i_div_rem;
   logic                 i_div_cancel;
   logic                 i_rs1_en;
   logic                 i_rs2_en;
   logic                 i_select_pc;
   logic [W-1:0]         i_gpr_rs1;
   logic [W-1:0]         i_gpr_rs2;
   logic [W-1:0]         i_immed;
   logic [W-1:1]         i_pc;
   logic [BYP_SRC_N-1:0] i_rs1_bypass_en;
   logic [BYP_SRC_N-1:0] i_rs2_bypass_en;
   logic [W-1:0]         i_result_r;
   logic [W-1:0]         i_lsu_result_m;
   logic [W-1:0]         i_nonblock_load_data;
   logic [W-1:0]         o_result_x;
   logic                 o_valid_x;
   logic [W-1:0]         o_div_result;
   logic                 o_div_wren;
   logic                 o_div_busy;

   string        kinds[$];
   logic [7:0]   ctls[$];
   logic [W-1:0] va[$];
   logic [W-1:0] vb[$];
   logic [W-1:0] vexp[$];
   int           seed   = 32'h999a;
   int           cycles = 0;
   int           limit  = 0;
   int           errs   = 0;
   int           n_run  = 0;
   int           n_fail = 0;

   exu_top #(.XLEN(W)) uut (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;                          // 8 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Run stopped by timeout after %0d cycles", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check(input logic [W-1:0] got, input logic [W-1:0] exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
         errs++;
      end
   endtask

   // Nothing issued, random padding on the data buses
   task automatic idle();
      logic [W-1:0] pc_rand;
      i_data_en            = 1'b1;
      i_flush_lower        = 1'b0;
      i_alu_valid_d        = 1'b0;
      i_alu_op_d           = ALU_ADD;
      i_mul_valid_d        = 1'b0;
      i_div_valid_d        = 1'b0;
      i_div_cancel         = 1'b0;
      i_select_pc          = 1'b0;
      i_rs1_en             = 1'b1;
      i_rs2_en             = 1'b1;
      i_rs1_bypass_en      = '0;
      i_rs2_bypass_en      = '0;
      i_gpr_rs1            = $random(seed);
      i_gpr_rs2            = $random(seed);
      i_immed              = $random(seed);
      pc_rand              = $random(seed);
      i_pc                 = pc_rand[W-1:1];
      i_result_r           = $random(seed);
      i_lsu_result_m       = $random(seed);
      i_nonblock_load_data = $random(seed);
   endtask

   task automatic issue_add(input logic [W-1:0] a, input logic [W-1:0] b);
      idle();
      i_alu_valid_d = 1'b1;
      i_gpr_rs1     = a;
      i_gpr_rs2     = b;
      step();
      idle();
   endtask

   task automatic divide(input logic [7:0] c, input logic [W-1:0] a, input logic [W-1:0] b,
                         input logic [W-1:0] exp);
      int n;
      idle();
      i_div_valid_d  = 1'b1;
      i_div_unsigned = c[0];
      i_div_rem      = c[1];
      i_gpr_rs1      = a;
      i_gpr_rs2      = b;
      step();                                      // Acceptance edge
      n = 1;
      idle();
      check(W'(o_div_busy), 1, "busy after accept");
      while (!o_div_wren && n < DIV_LAT + 6) begin
         step();
         n++;
      end
      if (!o_div_wren) begin
         $display("Divider never raised o_div_wren at %0t", $time);
         errs++;
      end else begin
         check(W'(n), W'(DIV_LAT), "divide latency");
         check(o_div_result, exp, "divide result");
      end
      step();
      check(W'(o_div_wren), 0, "wren after pulse");
      check(W'(o_div_busy), 0, "busy after write");
   endtask

   task automatic cancel_divide(input logic [7:0] c, input logic [W-1:0] a,
                                input logic [W-1:0] b);
      idle();
      i_div_valid_d  = 1'b1;
      i_div_unsigned = c[0];
      i_div_rem      = c[1];
      i_gpr_rs1      = a;
      i_gpr_rs2      = b;
      step();
      idle();
      repeat (4) step();
      i_div_cancel = 1'b1;
      step();
      i_div_cancel = 1'b0;
      check(W'(o_div_busy), 0, "busy after cancel");
      for (int k = 0; k < DIV_LAT; k++) begin
         if (o_div_wren) begin
            $display("Cancelled divide still wrote a result at %0t", $time);
            errs++;
         end
         step();
      end
   endtask

   // Bypass one operand from the source picked by c[1:0], c[2] moves it to rs2
   task automatic forward_add(input logic [7:0] c, input logic [W-1:0] a,
                              input logic [W-1:0] b, input logic [W-1:0] exp);
      logic [W-1:0] src;
      src = c[2] ? b : a;
      if (c[1:0] == 2'd2) begin
         issue_add(src, 0);                        // Producer of the X result
      end else begin
         idle();
      end
      i_alu_valid_d = 1'b1;
      i_gpr_rs1     = a;
      i_gpr_rs2     = b;
      case (c[1:0])
         2'd0:    i_result_r           = src;
         2'd1:    i_lsu_result_m       = src;
         2'd3:    i_nonblock_load_data = src;
         default: ;
      endcase
      if (c[2]) begin
         i_rs2_bypass_en = 4'b0001 << c[1:0];
         i_gpr_rs2       = $random(seed);
      end else begin
         i_rs1_bypass_en = 4'b0001 << c[1:0];
         i_gpr_rs1       = $random(seed);
      end
      step();
      idle();
      check(W'(o_valid_x), 1, "bypass valid");
      check(o_result_x, exp, "bypass result");
   endtask

   task automatic perform_test(input string k, input logic [7:0] c, input logic [W-1:0] a,
                               input logic [W-1:0] b, input logic [W-1:0] exp);
      idle();
      case (k)
         "alu": begin
            i_alu_valid_d = 1'b1;
            i_alu_op_d    = alu_op_e'(c[3:0]);
            i_select_pc   = c[5];
            i_rs1_en      = ~c[5];
            i_pc          = a[W-1:1];
            i_gpr_rs1     = a;
            i_rs2_en      = ~c[4];
            i_gpr_rs2     = b;
            i_immed       = b;
            step();
            idle();
            check(W'(o_valid_x), 1, "alu valid");
            check(o_result_x, exp, "alu result");
         end
         "mul": begin
            i_mul_valid_d  = 1'b1;
            i_mul_rs1_sign = c[0];
            i_mul_rs2_sign = c[1];
            i_mul_high     = c[2];
            i_gpr_rs1      = a;
            i_gpr_rs2      = b;
            step();
            idle();
            check(W'(o_valid_x), 1, "mul valid");
            check(o_result_x, exp, "mul result");
         end
         "div":    divide(c, a, b, exp);
         "cancel": cancel_divide(c, a, b);
         "byp":    forward_add(c, a, b, exp);
         "stall": begin
            issue_add(a, b);
            i_data_en  = 1'b0;
            i_alu_op_d = ALU_SUB;                  // Must be ignored
            for (int s = 0; s < 3; s++) begin
               i_alu_valid_d = (s == 0);           // An issue, then bubbles
               step();
               check(W'(o_valid_x), 1, "valid held in stall");
               check(o_result_x, exp, "result held in stall");
            end
         end
         "flush": begin
            issue_add(a, b);
            check(W'(o_valid_x), 1, "valid before flush");
            i_data_en     = 1'b0;
            i_flush_lower = 1'b1;
            step();
            i_flush_lower = 1'b0;
            check(W'(o_valid_x), 0, "valid after flush");
            check(o_result_x, exp, "result after flush");
         end
         default: begin
            $display("Unknown test kind %s in vector file", k);
            errs++;
         end
      endcase
   endtask

   initial begin
      int     fd;
      int     rc;
      string  line;
      string  k;
      logic [7:0]   c;
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] e;
      i_arst_n       = 1'b0;
      i_mul_rs1_sign = 1'b0;
      i_mul_rs2_sign = 1'b0;
      i_mul_high     = 1'b0;
      i_div_unsigned = 1'b0;
      i_div_rem      = 1'b0;
      idle();
      fd = $fopen("exu_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file exu_tests.txt");
         $display("Done: errors found");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
            if ($sscanf(line, "%s %h %h %h %h", k, c, a, b, e) == 5) begin
               kinds.push_back(k);
               ctls.push_back(c);
               va.push_back(a);
               vb.push_back(b);
               vexp.push_back(e);
            end
         end
         $fclose(fd);
         limit = kinds.size() * 40 + 100;
         repeat (5) step();
         i_arst_n = 1'b1;
         errs = 0;
         check(W'(o_valid_x), 0, "valid after reset");
         check(W'(o_div_wren), 0, "wren after reset");
         check(W'(o_div_busy), 0, "busy after reset");
         check(o_result_x, 0, "result after reset");
         n_run++;
         if (errs > 0) n_fail++;
         $display("test 0 reset: %s", (errs > 0) ? "FAIL" : "ok");
         for (int i = 0; i < kinds.size(); i++) begin
            errs = 0;
            perform_test(kinds[i], ctls[i], va[i], vb[i], vexp[i]);
            n_run++;
            if (errs > 0) n_fail++;
            $display("test %0d %s: %s", i + 1, kinds[i], (errs > 0) ? "FAIL" : "ok");
         end
         $display("Tests run %0d, failed %0d, cycles %0d", n_run, n_fail, cycles);
         if (n_fail == 0) begin
            $display("Done: no errors");
         end else begin
            $display("Done: errors found");
         end
         $finish;
      end
   end

endmodule
